/* source/emesh_pkg.sv */
package emesh_pkg;

   localparam int PW = 104;                     // Full mesh packet width
   localparam int AW = 32;                      // Address width
   localparam int DW = 32;                      // Data width
   localparam int CW = 4;                       // Ctrlmode width
   localparam int SW = PW - 2*AW - DW - CW - 3; // Spare bits below the write flag

   // Transfer size encoding of the mesh
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,                         // 8 bit access
      DM_HALF   = 2'd1,                         // 16 bit access
      DM_WORD   = 2'd2,                         // 32 bit access
      DM_DOUBLE = 2'd3                          // 64 bit access on the mesh
   } emesh_datamode_t;

   // Packet layout with srcaddr at the top
   typedef struct packed {
      logic [AW-1:0]   srcaddr;                 // Bits 103:72
      logic [DW-1:0]   data;                    // Bits 71:40
      logic [AW-1:0]   dstaddr;                 // Bits 39:8
      logic [CW-1:0]   ctrlmode;                // Bits 7:4
      emesh_datamode_t datamode;                // Bits 3:2
      logic            write;                   // Bit 1
      logic [SW-1:0]   spare;                   // Bit 0
   } emesh_packet_t;

endpackage

/* source/emem_pkg.sv */
package emem_pkg;

   localparam int IDW = 12;                     // Chip ID width
   localparam logic [IDW-1:0] LINK_ID = 12'h820; // ID of this link
   localparam int MEM_DEPTH = 256;              // Words in the memory
   localparam int MEM_AW = 8;                   // Word index width
   localparam int NB = emesh_pkg::DW / 8;       // Byte lanes per word
   localparam int OFS_W = $clog2(NB);           // Byte offset width
   localparam int HI_W = emesh_pkg::AW - MEM_AW - OFS_W; // Upper dstaddr bits kept

   // Request as seen by the memory stage
   typedef struct packed {
      logic                       write;        // Write when set
      emesh_pkg::emesh_datamode_t datamode;     // Double already folded
      logic [emesh_pkg::CW-1:0]   ctrlmode;
      logic [OFS_W-1:0]           offset;       // Byte within word
      logic [MEM_AW-1:0]          index;        // Word index
      logic [emesh_pkg::DW-1:0]   wdata;
      logic [emesh_pkg::AW-1:0]   retaddr;      // Requester srcaddr
      logic [HI_W-1:0]            dst_hi;       // Dstaddr bits 31:10
   } emem_req_t;

   // Raw read result before lane extraction
   typedef struct packed {
      logic [emesh_pkg::DW-1:0]   word;         // Stored word
      logic [OFS_W-1:0]           offset;
      emesh_pkg::emesh_datamode_t datamode;
      logic [emesh_pkg::CW-1:0]   ctrlmode;
      logic [emesh_pkg::AW-1:0]   retaddr;
      logic [emesh_pkg::AW-1:0]   rdaddr;       // Rebuilt read address
   } emem_rdraw_t;

endpackage

/* source/emesh_decode.sv */
`timescale 1ns/1ps

module emesh_decode
   import emesh_pkg::*, emem_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          req_access,      // Single cycle packet strobe
   input  emesh_packet_t req_packet,
   output logic          req_valid,       // Memory request strobe
   output emem_req_t     req
);

   logic      link_hit;                   // Packet addressed to the link
   logic      mem_hit;                    // Packet goes to memory
   emem_req_t req_next;

   // Upper dstaddr bits carry the chip ID
   assign link_hit = (req_packet.dstaddr[AW-1 -: IDW] == LINK_ID);
   assign mem_hit  = req_access & ~link_hit;

   always_comb begin
      req_next.write    = req_packet.write;
      req_next.ctrlmode = req_packet.ctrlmode;
      req_next.offset   = req_packet.dstaddr[OFS_W-1:0];      // Byte lane
      req_next.index    = req_packet.dstaddr[OFS_W +: MEM_AW]; // Bits 9:2
      req_next.dst_hi   = req_packet.dstaddr[AW-1 -: HI_W];   // Bits 31:10
      req_next.wdata    = req_packet.data;
      req_next.retaddr  = req_packet.srcaddr;                 // Response goes here
      // Double is served as a plain word
      if (req_packet.datamode == DM_DOUBLE) begin
         req_next.datamode = DM_WORD;
      end else begin
         req_next.datamode = req_packet.datamode;
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         req_valid <= 1'b0;
      end else begin
         req_valid <= mem_hit;            // Local packets dropped here
      end
   end

   // Payload only loads for accepted packets
   always_ff @(posedge clkin) begin
      if (mem_hit) begin
         req <= req_next;
      end
   end

endmodule

/* source/emem_execute.sv */
`timescale 1ns/1ps

module emem_execute
   import emesh_pkg::*, emem_pkg::*;
(
   input  logic        clkin,
   input  logic        reset,
   input  logic        req_valid,         // Request strobe from decode
   input  emem_req_t   req,
   output logic        rd_valid,          // Read data strobe
   output emem_rdraw_t rd_raw
);

   logic [DW-1:0] mem [MEM_DEPTH];        // Word array
   logic [NB-1:0] lane_en;                // Byte write enables
   logic [DW-1:0] lane_data;              // Write data steered to lanes
   logic          wr_hit;
   logic          rd_hit;

   assign wr_hit = req_valid & req.write;
   assign rd_hit = req_valid & ~req.write;

   // Lane mask and data replication by size
   always_comb begin
      case (req.datamode)
         DM_BYTE: begin
            lane_en   = NB'(1) << req.offset;               // One lane
            lane_data = {NB{req.wdata[7:0]}};               // Low byte everywhere
         end
         DM_HALF: begin
            lane_en   = NB'(3) << {req.offset[1], 1'b0};    // Aligned half
            lane_data = {(NB/2){req.wdata[15:0]}};          // Low half twice
         end
         default: begin
            lane_en   = '1;                                 // Whole word
            lane_data = req.wdata;
         end
      endcase
   end

   // Write lands on the edge that samples req_valid
   always_ff @(posedge clkin) begin
      if (wr_hit) begin
         for (int b = 0; b < NB; b++) begin
            if (lane_en[b]) begin
               mem[req.index][8*b +: 8] <= lane_data[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_hit;              // Writes give no response
      end
   end

   // Registered read with response context
   always_ff @(posedge clkin) begin
      if (rd_hit) begin
         rd_raw.word     <= mem[req.index];
         rd_raw.offset   <= req.offset;
         rd_raw.datamode <= req.datamode;
         rd_raw.ctrlmode <= req.ctrlmode;
         rd_raw.retaddr  <= req.retaddr;
         rd_raw.rdaddr   <= {req.dst_hi, req.index, req.offset}; // Original dstaddr
      end
   end

endmodule

/* source/emesh_result.sv */
`timescale 1ns/1ps

module emesh_result
   import emesh_pkg::*, emem_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          rd_valid,        // Raw read strobe
   input  emem_rdraw_t   rd_raw,
   output logic          rsp_access,      // Response strobe
   output emesh_packet_t rsp_packet
);

   logic [DW-1:0] lane_word;              // Selected lane at bit 0

   // Shift addressed lane down and zero extend
   always_comb begin
      case (rd_raw.datamode)
         DM_BYTE: begin
            lane_word = DW'(rd_raw.word[8*rd_raw.offset +: 8]);
         end
         DM_HALF: begin
            lane_word = DW'(rd_raw.word[16*rd_raw.offset[1] +: 16]);
         end
         default: begin
            lane_word = rd_raw.word;      // Word passes as is
         end
      endcase
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         rsp_access <= 1'b0;
      end else begin
         rsp_access <= rd_valid;
      end
   end

   // Response is a write back to the requester
   always_ff @(posedge clkin) begin
      if (rd_valid) begin
         rsp_packet.srcaddr  <= rd_raw.rdaddr;   // Address that was read
         rsp_packet.data     <= lane_word;
         rsp_packet.dstaddr  <= rd_raw.retaddr;  // Back to requester
         rsp_packet.ctrlmode <= rd_raw.ctrlmode; // Echoed
         rsp_packet.datamode <= rd_raw.datamode; // Echoed
         rsp_packet.write    <= 1'b1;
         rsp_packet.spare    <= '0;
      end
   end

endmodule

/* source/emem_top.sv */
`timescale 1ns/1ps

module emem_top
   import emesh_pkg::*, emem_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          req_access,      // Incoming mesh strobe
   input  emesh_packet_t req_packet,
   output logic          rsp_access,      // Read response strobe
   output emesh_packet_t rsp_packet
);

   logic        req_valid;                // Decode to execute
   emem_req_t   req;
   logic        rd_valid;                 // Execute to result
   emem_rdraw_t rd_raw;

   // Filter link traffic and slice fields
   emesh_decode u_decode (
      .clkin      (clkin),
      .reset      (reset),
      .req_access (req_access),
      .req_packet (req_packet),
      .req_valid  (req_valid),
      .req        (req)
   );

   // Memory array
   emem_execute u_execute (
      .clkin     (clkin),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .rd_valid  (rd_valid),
      .rd_raw    (rd_raw)
   );

   // Response packet builder
   emesh_result u_result (
      .clkin      (clkin),
      .reset      (reset),
      .rd_valid   (rd_valid),
      .rd_raw     (rd_raw),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet)
   );

endmodule

/* verif/emem_assert.sv */
`timescale 1ns/1ps

module emem_assert
   import emesh_pkg::*;
(
   input logic          clkin,
   input logic          reset,
   input logic          req_access,   // Request strobe at the top level
   input emesh_packet_t req_packet,
   input logic          rsp_access,   // Response strobe at the top level
   input emesh_packet_t rsp_packet
);

   // Response strobe stays low in reset
   rsp_quiet_in_reset: assert property (@(posedge clkin) reset |-> !rsp_access)
      else $error("rsp_access high while reset is asserted");

   // Three stage pipeline, only reads come back
   rsp_from_read: assert property (@(posedge clkin) disable iff (reset)
      rsp_access |-> $past(req_access && !req_packet.write, 3))
      else $error("rsp_access without a read request three cycles earlier");

   // Responses travel as writes to the requester
   rsp_is_write: assert property (@(posedge clkin) disable iff (reset)
      rsp_access |-> rsp_packet.write)
      else $error("response packet has its write bit clear");

endmodule

bind emem_top emem_assert u_emem_assert (.*);

/* verif/emem_tb.sv */
`timescale 1ns/1ps

module emem_tb
   import emesh_pkg::*, emem_pkg::*;
();

   localparam int PERIOD    = 8;          // Clock period in ns
   localparam int RST_CYC   = 8;          // Reset length in cycles
   localparam int LATENCY   = 3;          // Request strobe to response strobe
   localparam int MAX_TESTS = 32;         // Size of the result arrays
   localparam int DRAIN_MAX = 8;          // Longest wait for pending responses
   localparam int QUIET     = 4;          // Idle cycles that catch stray responses

   // One row of the stimulus table
   typedef struct packed {
      logic            write;
      emesh_datamode_t datamode;
      logic [3:0]      ctrlmode;
      logic [31:0]     dstaddr;
      logic [31:0]     data;
      logic [31:0]     srcaddr;
      logic            chain;             // Next row goes out on the following cycle
      logic            rsp;               // Read response expected
      logic [31:0]     exp_data;          // Zero-extended lane value
   } test_t;

   logic          clkin;
   logic          reset;
   logic          req_access;
   emesh_packet_t req_packet;
   logic          rsp_access;
   emesh_packet_t rsp_packet;

   test_t       tbl [$];                  // Stimulus table
   string       names [$];                // Test names, same order
   int          pend_idx [$];             // Rows waiting for a response
   int          pend_cyc [$];             // Edge where the DUT sampled each row
   bit          got   [MAX_TESTS];
   bit          bad   [MAX_TESTS];
   string       what  [MAX_TESTS];        // Field of the first mismatch
   logic [31:0] exp_v [MAX_TESTS];
   logic [31:0] act_v [MAX_TESTS];
   int          cyc;                      // Rising edges since time zero
   int          strays;                   // Responses with nothing pending
   int          pass_cnt;
   int          fail_cnt;
   bit          tbl_ready;

   emem_top u_emem_top (
      .clkin      (clkin),
      .reset      (reset),
      .req_access (req_access),
      .req_packet (req_packet),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet)
   );

   always #(PERIOD/2) clkin = ~clkin;

   always @(posedge clkin) begin
      cyc <= cyc + 1;
   end

   task automatic add_test(input string name, input logic wr, input emesh_datamode_t dm,
                           input logic [3:0] ctrl, input logic [31:0] dst,
                           input logic [31:0] data, input logic [31:0] src,
                           input logic chain, input logic rsp, input logic [31:0] exp_data);
      test_t t;
      t.write    = wr;
      t.datamode = dm;
      t.ctrlmode = ctrl;
      t.dstaddr  = dst;
      t.data     = data;
      t.srcaddr  = src;
      t.chain    = chain;
      t.rsp      = rsp;
      t.exp_data = exp_data;
      tbl.push_back(t);
      names.push_back(name);
   endtask

   task automatic build_table();
      // name, wr, datamode, ctrl, dstaddr, data, srcaddr, chain, rsp, expected data
      add_test("wr_word",   1'b1, DM_WORD,   4'h0, 32'h40, 32'hdead_beef, 32'h0,   1'b0, 1'b0, 32'h0);
      add_test("rd_word",   1'b0, DM_WORD,   4'h5, 32'h40, 32'h0,  32'ha01, 1'b0, 1'b1, 32'hdead_beef);
      // Upper dstaddr bits alias word 0x10 and come back in srcaddr
      add_test("rd_double", 1'b0, DM_DOUBLE, 4'h6, 32'h5a5a_5c40, 32'h0, 32'ha02,
               1'b0, 1'b1, 32'hdead_beef);
      // Lane merge in word 0x20
      add_test("wr_base",   1'b1, DM_WORD,   4'h0, 32'h80, 32'h1111_1111, 32'h0,   1'b0, 1'b0, 32'h0);
      add_test("wr_byte1",  1'b1, DM_BYTE,   4'h0, 32'h81, 32'h5566_77ab, 32'h0,   1'b0, 1'b0, 32'h0);
      add_test("wr_half2",  1'b1, DM_HALF,   4'h0, 32'h82, 32'h9988_cdef, 32'h0,   1'b0, 1'b0, 32'h0);
      add_test("rd_merged", 1'b0, DM_WORD,   4'h1, 32'h80, 32'h0,  32'ha03, 1'b0, 1'b1, 32'hcdef_ab11);
      // Narrow reads of 0xcdefab11
      add_test("rd_byte0",  1'b0, DM_BYTE,   4'h2, 32'h80, 32'h0,  32'ha04, 1'b0, 1'b1, 32'h11);
      add_test("rd_byte1",  1'b0, DM_BYTE,   4'h3, 32'h81, 32'h0,  32'ha05, 1'b0, 1'b1, 32'hab);
      add_test("rd_byte2",  1'b0, DM_BYTE,   4'h4, 32'h82, 32'h0,  32'ha06, 1'b0, 1'b1, 32'hef);
      add_test("rd_byte3",  1'b0, DM_BYTE,   4'h4, 32'h83, 32'h0,  32'ha07, 1'b0, 1'b1, 32'hcd);
      add_test("rd_half0",  1'b0, DM_HALF,   4'h7, 32'h80, 32'h0,  32'ha08, 1'b0, 1'b1, 32'hab11);
      add_test("rd_half2",  1'b0, DM_HALF,   4'h8, 32'h82, 32'h0,  32'ha09, 1'b0, 1'b1, 32'hcdef);
      // Link traffic aliases word 0x10 but must not reach it
      add_test("wr_link",   1'b1, DM_WORD,   4'h0, {LINK_ID, 20'h00040}, 32'hbad0_bad0, 32'h0,
               1'b0, 1'b0, 32'h0);
      add_test("rd_link",   1'b0, DM_WORD,   4'h9, {LINK_ID, 20'h00040}, 32'h0, 32'ha0a,
               1'b0, 1'b0, 32'h0);
      add_test("rd_alias",  1'b0, DM_WORD,   4'ha, 32'h40, 32'h0,  32'ha0b, 1'b0, 1'b1, 32'hdead_beef);
      // Back to back burst in word 0x30
      add_test("b2b_wr",    1'b1, DM_WORD,   4'h0, 32'hc0, 32'h0f1e_2d3c, 32'h0,   1'b1, 1'b0, 32'h0);
      add_test("b2b_rd0",   1'b0, DM_WORD,   4'hb, 32'hc0, 32'h0,  32'ha0c, 1'b1, 1'b1, 32'h0f1e_2d3c);
      add_test("b2b_rd1",   1'b0, DM_BYTE,   4'hc, 32'hc2, 32'h0,  32'ha0d, 1'b1, 1'b1, 32'h1e);
      add_test("b2b_hw",    1'b1, DM_HALF,   4'h0, 32'hc2, 32'h0000_7788, 32'h0,   1'b1, 1'b0, 32'h0);
      add_test("b2b_rd2",   1'b0, DM_WORD,   4'hd, 32'hc0, 32'h0,  32'ha0e, 1'b1, 1'b1, 32'h7788_2d3c);
      add_test("b2b_rd3",   1'b0, DM_WORD,   4'he, 32'h40, 32'h0,  32'ha0f, 1'b0, 1'b1, 32'hdead_beef);
   endtask

   task automatic drive_row(input int idx);
      test_t         t;
      emesh_packet_t p;
      t = tbl[idx];
      p.srcaddr  = t.srcaddr;
      p.data     = t.data;
      p.dstaddr  = t.dstaddr;
      p.ctrlmode = t.ctrlmode;
      p.datamode = t.datamode;
      p.write    = t.write;
      p.spare    = '0;
      req_access <= 1'b1;
      req_packet <= p;
      if (t.rsp) begin
         pend_idx.push_back(idx);
         pend_cyc.push_back(cyc + 1);     // DUT samples on the next edge
      end
   endtask

   task automatic mark_bad(input int idx, input string fld, input logic [31:0] e,
                           input logic [31:0] a);
      if (!bad[idx]) begin
         bad[idx]   = 1'b1;
         what[idx]  = fld;
         exp_v[idx] = e;
         act_v[idx] = a;
      end
   endtask

   task automatic check_rsp(input int idx, input int issued);
      test_t           t;
      emesh_datamode_t dm;
      t = tbl[idx];
      dm = (t.datamode == DM_DOUBLE) ? DM_WORD : t.datamode; // Double served as word
      got[idx]   = 1'b1;
      exp_v[idx] = t.exp_data;
      act_v[idx] = rsp_packet.data;
      if (cyc - issued != LATENCY) begin
         mark_bad(idx, "latency", 32'(LATENCY), 32'(cyc - issued));
      end
      if (rsp_packet.data != t.exp_data) begin
         mark_bad(idx, "data", t.exp_data, rsp_packet.data);
      end
      if (rsp_packet.dstaddr != t.srcaddr) begin
         mark_bad(idx, "dstaddr", t.srcaddr, rsp_packet.dstaddr);
      end
      if (rsp_packet.srcaddr != t.dstaddr) begin
         mark_bad(idx, "srcaddr", t.dstaddr, rsp_packet.srcaddr);
      end
      if (rsp_packet.ctrlmode != t.ctrlmode) begin
         mark_bad(idx, "ctrlmode", 32'(t.ctrlmode), 32'(rsp_packet.ctrlmode));
      end
      if (rsp_packet.datamode != dm) begin
         mark_bad(idx, "datamode", 32'(dm), 32'(rsp_packet.datamode));
      end
      if (rsp_packet.write != 1'b1 || rsp_packet.spare != '0) begin
         mark_bad(idx, "write/spare", 32'h2, 32'({rsp_packet.write, rsp_packet.spare}));
      end
   endtask

   // Response monitor, matches strobes against the pending queue in order
   always @(posedge clkin) begin
      if (rsp_access) begin
         if (pend_idx.size() == 0) begin
            strays = strays + 1;
         end else begin
            check_rsp(pend_idx.pop_front(), pend_cyc.pop_front());
         end
      end
   end

   task automatic report_group(input int first, input int last);
      for (int j = first; j <= last; j++) begin
         if (tbl[j].rsp && !got[j]) begin
            $display("FAIL %s: no response arrived for this read", names[j]);
            fail_cnt++;
         end else if (j == last && strays != 0) begin
            $display("FAIL %s: %0d response(s) arrived when none was expected", names[j], strays);
            fail_cnt++;
         end else if (bad[j]) begin
            $display("FAIL %s: %s expected %h actual %h", names[j], what[j], exp_v[j], act_v[j]);
            fail_cnt++;
         end else if (tbl[j].rsp) begin
            $display("PASS %s: data expected %h actual %h", names[j], exp_v[j], act_v[j]);
            pass_cnt++;
         end else begin
            $display("PASS %s: no response, none expected", names[j]);
            pass_cnt++;
         end
      end
      strays = 0;
      pend_idx.delete();                  // Late responses count as strays later
      pend_cyc.delete();
   endtask

   task automatic drain_group(input int first, input int last);
      int waited;
      waited = 0;
      while (pend_idx.size() != 0 && waited < DRAIN_MAX) begin
         @(posedge clkin);
         waited++;
      end
      repeat (QUIET) @(posedge clkin);    // Window for responses that should not come
      report_group(first, last);
   endtask

   initial begin
      int first;
      clkin      = 1'b0;
      reset      = 1'b1;
      req_access = 1'b0;
      req_packet = '0;
      first      = 0;
      build_table();
      tbl_ready = 1'b1;
      repeat (RST_CYC) @(posedge clkin);
      reset <= 1'b0;
      @(posedge clkin);
      for (int i = 0; i < tbl.size(); i++) begin
         @(posedge clkin);
         drive_row(i);
         if (!tbl[i].chain) begin
            @(posedge clkin);
            req_access <= 1'b0;
            drain_group(first, i);
            first = i + 1;
         end
      end
      $display("Tests %0d, passed %0d, failed %0d", tbl.size(), pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      int limit;
      wait (tbl_ready);
      limit = (tbl.size() + 8) * 10 + RST_CYC;
      repeat (limit) @(posedge clkin);
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* verilog.f */
source/emesh_pkg.sv
source/emem_pkg.sv
source/emesh_decode.sv
source/emem_execute.sv
source/emesh_result.sv
source/emem_top.sv
verif/emem_assert.sv
verif/emem_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := emem_tb
FILELIST := verilog.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := ALL CHECKS PASSED

.PHONY: all run clean

all: run

# Rebuilt only when a source, the file list or this file changes
$(BIN): $(SRCS) $(FILELIST) Makefile
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
